/* Makefile */
# Verilator build and run of the vector slide unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module vsld_tb -Mdir obj_dir
	./obj_dir/Vvsld_tb | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/vsld_pkg.sv */
/*
 * vector slide unit, shared operation and element width types
 * plus the default register and chunk sizes
 */
package vsld_pkg;

    // slide operation kind
    typedef enum logic [1:0] {
        SLD_UP    = 2'd0,
        SLD_DOWN  = 2'd1,
        SLD_1UP   = 2'd2,
        SLD_1DOWN = 2'd3
    } sld_op_e;

    // element width, encoded as log2 of the element byte count
    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vsew_e;

    // default vector register width in bits
    localparam int unsigned VREG_W_DEF   = 128;

    // default width of one processed chunk
    localparam int unsigned SLD_OP_W_DEF = 32;

endpackage

/* hdl/vsld_top.sv */
`timescale 1ns/1ps

/*
 * vector slide unit top level, sequencer, operand buffer and result assembly
 */
module vsld_top #(
    parameter  int unsigned VREG_W   = vsld_pkg::VREG_W_DEF,
    parameter  int unsigned SLD_OP_W = vsld_pkg::SLD_OP_W_DEF,
    localparam int unsigned VL_W     = $clog2(VREG_W / 8) + 1
) (
    input  logic                clk_i,
    input  logic                async_rst_ni,

    input  logic                op_rdy_i,
    output logic                op_ack_o,
    input  vsld_pkg::sld_op_e   op_i,
    input  vsld_pkg::vsew_e     sew_i,
    input  logic [VL_W-1:0]     vl_i,
    input  logic [31:0]         rs1_i,
    input  logic [4:0]          vd_i,
    input  logic [VREG_W-1:0]   src_i,

    output logic                vreg_wr_en_o,
    output logic [VREG_W-1:0]   vreg_wr_o,
    output logic [4:0]          vreg_wr_addr_o,
    output logic [VREG_W/8-1:0] vreg_wr_mask_o
);

    localparam int unsigned CHUNKS = VREG_W / SLD_OP_W;
    localparam int unsigned SHFT_W = $clog2(SLD_OP_W / 8);
    localparam int unsigned IDX_W  = $clog2(CHUNKS) + 3;

    if ((VREG_W & (VREG_W - 1)) != 0 || VREG_W < 64 ||
        (SLD_OP_W & (SLD_OP_W - 1)) != 0 || SLD_OP_W < 32 || SLD_OP_W >= VREG_W) begin : g_bad_cfg
        $fatal(1, "VREG_W and SLD_OP_W must be powers of two, 64 <= VREG_W, 32 <= SLD_OP_W < VREG_W");
    end

    // sequencer beat fields
    logic                    load;
    logic [VREG_W-1:0]       src;
    logic                    beat_valid, beat_first, beat_last;
    logic signed [IDX_W-1:0] src_chunk;
    logic [SHFT_W-1:0]       op_shift;
    vsld_pkg::sld_op_e       op;
    vsld_pkg::vsew_e         sew;
    logic [VL_W-1:0]         vl;
    logic [31:0]             rs1;
    logic [4:0]              vd;

    // same fields one cycle later, plus operands
    logic                    b_valid, b_first, b_last;
    logic signed [IDX_W-1:0] b_src_chunk;
    logic [SHFT_W-1:0]       b_op_shift;
    vsld_pkg::sld_op_e       b_op;
    vsld_pkg::vsew_e         b_sew;
    logic [VL_W-1:0]         b_vl;
    logic [31:0]             b_rs1;
    logic [4:0]              b_vd;
    logic [SLD_OP_W-1:0]     operand_low, operand_high;
    logic                    low_valid, high_valid;

    vsld_sequencer #(
        .VREG_W   (VREG_W),
        .SLD_OP_W (SLD_OP_W)
    ) u_sequencer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_rdy_i     (op_rdy_i),
        .op_ack_o     (op_ack_o),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .vl_i         (vl_i),
        .rs1_i        (rs1_i),
        .vd_i         (vd_i),
        .src_i        (src_i),
        .load_o       (load),
        .src_o        (src),
        .beat_valid_o (beat_valid),
        .beat_first_o (beat_first),
        .beat_last_o  (beat_last),
        .src_chunk_o  (src_chunk),
        .op_shift_o   (op_shift),
        .op_o         (op),
        .sew_o        (sew),
        .vl_o         (vl),
        .rs1_o        (rs1),
        .vd_o         (vd)
    );

    vsld_operand_buf #(
        .VREG_W   (VREG_W),
        .SLD_OP_W (SLD_OP_W)
    ) u_operand_buf (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .load_i         (load),
        .src_i          (src),
        .beat_valid_i   (beat_valid),
        .beat_first_i   (beat_first),
        .beat_last_i    (beat_last),
        .src_chunk_i    (src_chunk),
        .op_shift_i     (op_shift),
        .op_i           (op),
        .sew_i          (sew),
        .vl_i           (vl),
        .rs1_i          (rs1),
        .vd_i           (vd),
        .beat_valid_o   (b_valid),
        .beat_first_o   (b_first),
        .beat_last_o    (b_last),
        .src_chunk_o    (b_src_chunk),
        .op_shift_o     (b_op_shift),
        .op_o           (b_op),
        .sew_o          (b_sew),
        .vl_o           (b_vl),
        .rs1_o          (b_rs1),
        .vd_o           (b_vd),
        .operand_low_o  (operand_low),
        .operand_high_o (operand_high),
        .low_valid_o    (low_valid),
        .high_valid_o   (high_valid)
    );

    vsld_result_asm #(
        .VREG_W   (VREG_W),
        .SLD_OP_W (SLD_OP_W)
    ) u_result_asm (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .beat_valid_i   (b_valid),
        .beat_first_i   (b_first),
        .beat_last_i    (b_last),
        .src_chunk_i    (b_src_chunk),
        .op_shift_i     (b_op_shift),
        .op_i           (b_op),
        .sew_i          (b_sew),
        .vl_i           (b_vl),
        .rs1_i          (b_rs1),
        .vd_i           (b_vd),
        .operand_low_i  (operand_low),
        .operand_high_i (operand_high),
        .low_valid_i    (low_valid),
        .high_valid_i   (high_valid),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

/* verification/vsld_chk.sv */
`timescale 1ns/1ps

/*
 * vector slide unit checker, write strobe timing against acceptance
 */
module vsld_chk (
    input logic clk_i,
    input logic async_rst_ni,
    input logic op_rdy_i,
    input logic op_ack_i,
    input logic wr_en_i
);

    logic accept;

    assign accept = op_rdy_i & op_ack_i;

    // every acceptance gives a write 7 cycles later
    // strobe rises on the 7th edge, first sampled high on the 8th
    a_accept_to_write: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $past(accept, 8) |-> wr_en_i)
        else $error("no register write 7 cycles after an acceptance");

    // and no write without one
    a_write_from_accept: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_en_i |-> $past(accept, 8))
        else $error("register write without an acceptance 7 cycles earlier");

    a_quiet_in_reset: assert property (@(posedge clk_i)
        !async_rst_ni |-> !wr_en_i)
        else $error("register write strobe high during reset");

endmodule

bind vsld_top vsld_chk u_chk (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .op_rdy_i     (op_rdy_i),
    .op_ack_i     (op_ack_o),
    .wr_en_i      (vreg_wr_en_o)
);

/* verification/vsld_tb.sv */
`timescale 1ns/1ps

/*
 * vector slide unit testbench, replays the operation vectors with random
 * idle gaps, then back to back, and checks every register write
 */
module vsld_tb;

    localparam int unsigned VREG_W   = vsld_pkg::VREG_W_DEF;
    localparam int unsigned SLD_OP_W = vsld_pkg::SLD_OP_W_DEF;
    localparam int unsigned VL_W     = $clog2(VREG_W / 8) + 1;
    localparam int unsigned MSK_W    = VREG_W / 8;
    localparam int unsigned FIELDS   = 8;
    localparam int unsigned MAX_VEC  = 64;
    localparam int unsigned TIMEOUT  = 200;
    localparam int unsigned HALF     = 20;

    logic                   clk_i;
    logic                   async_rst_ni;
    logic                   op_rdy;
    logic                   op_ack;
    vsld_pkg::sld_op_e      op;
    vsld_pkg::vsew_e        sew;
    logic [VL_W-1:0]        vl;
    logic [31:0]            rs1;
    logic [4:0]             vd;
    logic [VREG_W-1:0]      src;
    logic                   wr_en;
    logic [VREG_W-1:0]      wr_data;
    logic [4:0]             wr_addr;
    logic [MSK_W-1:0]       wr_mask;

    // op, sew, vl, rs1, vd, src, expected data, expected mask per vector
    logic [VREG_W-1:0]      vec_mem [FIELDS*MAX_VEC];
    int                     nvec;
    int                     pend_q[$];
    logic [31:0]            lfsr = 32'h986f_3df6;
    int                     err_count = 0;
    int                     tests_ok = 0;
    int                     tests_bad = 0;
    int                     accepted = 0;
    int                     writes = 0;
    bit                     timed_out = 1'b0;

    vsld_top #(
        .VREG_W   (VREG_W),
        .SLD_OP_W (SLD_OP_W)
    ) dut_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy),
        .op_ack_o       (op_ack),
        .op_i           (op),
        .sew_i          (sew),
        .vl_i           (vl),
        .rs1_i          (rs1),
        .vd_i           (vd),
        .src_i          (src),
        .vreg_wr_en_o   (wr_en),
        .vreg_wr_o      (wr_data),
        .vreg_wr_addr_o (wr_addr),
        .vreg_wr_mask_o (wr_mask)
    );

    initial clk_i = 1'b0;
    always #(HALF) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_gap(output int gap);
        lfsr = lfsr_next(lfsr);
        gap  = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        gap  = gap | (int'(lfsr[0]) << 1);
    endtask

    function automatic logic [VREG_W-1:0] byte_bits(input logic [MSK_W-1:0] m);
        logic [VREG_W-1:0] r;
        for (int b = 0; b < MSK_W; b++) begin
            r[b*8 +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    function automatic string op_name(input logic [1:0] code);
        string s;
        case (code)
            2'd0:    s = "slide-up";
            2'd1:    s = "slide-down";
            2'd2:    s = "slide-1-up";
            default: s = "slide-1-down";
        endcase
        return s;
    endfunction

    task automatic compare(input string what, input logic [VREG_W-1:0] got,
                           input logic [VREG_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // drive one operation and hold it until acknowledged
    task automatic issue(input int n);
        int base;
        int waited;
        bit taken;
        base   = n * FIELDS;
        waited = 0;
        taken  = 1'b0;
        op     = vsld_pkg::sld_op_e'(vec_mem[base][1:0]);
        sew    = vsld_pkg::vsew_e'(vec_mem[base+1][1:0]);
        vl     = vec_mem[base+2][VL_W-1:0];
        rs1    = vec_mem[base+3][31:0];
        vd     = vec_mem[base+4][4:0];
        src    = vec_mem[base+5];
        op_rdy = 1'b1;
        while (!taken && !timed_out) begin
            // mid low phase, acknowledge is settled
            #(HALF / 2);
            if (op_ack) begin
                taken = 1'b1;
                pend_q.push_back(n);
                accepted++;
            end else if (waited >= TIMEOUT) begin
                $display("timeout: operation %0d was never acknowledged", n);
                timed_out = 1'b1;
            end
            waited++;
            @(negedge clk_i);
        end
    endtask

    task automatic check_write();
        int               n;
        int               base;
        int               errs_before;
        logic [MSK_W-1:0] exp_mask;
        logic [VREG_W-1:0] sel;
        writes++;
        if (pend_q.size() == 0) begin
            $display("register write at %0t ns with no operation outstanding", $time);
            err_count++;
        end else begin
            n           = pend_q.pop_front();
            base        = n * FIELDS;
            errs_before = err_count;
            exp_mask    = vec_mem[base+7][MSK_W-1:0];
            sel         = byte_bits(exp_mask);
            compare("write data", wr_data & sel, vec_mem[base+6] & sel);
            compare("write mask", VREG_W'(wr_mask), VREG_W'(exp_mask));
            compare("write address", VREG_W'(wr_addr), VREG_W'(vec_mem[base+4][4:0]));
            if (err_count == errs_before) begin
                tests_ok++;
            end else begin
                tests_bad++;
            end
            $display("test %0d %s sew %0d vl %0d rs1 %h vd %0d: %s",
                     tests_ok + tests_bad, op_name(vec_mem[base][1:0]),
                     8 << vec_mem[base+1][1:0], vec_mem[base+2][VL_W-1:0],
                     vec_mem[base+3][31:0], vec_mem[base+4][4:0],
                     (err_count == errs_before) ? "ok" : "mismatch");
        end
    endtask

    // write port is registered, so the falling edge sees it settled
    always @(negedge clk_i) begin
        if (async_rst_ni && wr_en) begin
            check_write();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin : main
        int gap;
        int waited;
        op_rdy       = 1'b0;
        op           = vsld_pkg::SLD_UP;
        sew          = vsld_pkg::VSEW_8;
        vl           = '0;
        rs1          = '0;
        vd           = '0;
        src          = '0;
        async_rst_ni = 1'b0;

        // fill marks unused entries with an op code above 3
        for (int a = 0; a < FIELDS * MAX_VEC; a++) begin
            vec_mem[a] = {(VREG_W / 32){32'(~a)}};
        end
        $readmemh("verification/vsld_vectors.txt", vec_mem);
        nvec = 0;
        while (nvec < MAX_VEC && vec_mem[nvec*FIELDS] <= 3) begin
            nvec++;
        end
        if (nvec == 0) begin
            $display("no operation vectors were read");
        end

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;

        // first pass with random gaps, second pass back to back
        for (int p = 0; p < 2; p++) begin
            for (int n = 0; n < nvec && !timed_out; n++) begin
                issue(n);
                if (p == 0) begin
                    pick_gap(gap);
                end else begin
                    gap = 0;
                end
                if (gap > 0) begin
                    op_rdy = 1'b0;
                    repeat (gap) @(negedge clk_i);
                end
            end
        end
        op_rdy = 1'b0;

        waited = 0;
        while (pend_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (pend_q.size() != 0) begin
            $display("timeout: %0d register writes never arrived", pend_q.size());
            timed_out = 1'b1;
        end
        // quiet period to catch stray writes
        repeat (8) @(negedge clk_i);
        compare("write count", VREG_W'(writes), VREG_W'(accepted));

        $display("tests %0d, ok %0d, mismatched %0d, errors %0d",
                 tests_ok + tests_bad, tests_ok, tests_bad, err_count);
        if (err_count == 0 && !timed_out && nvec > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verification/vsld_vectors.txt */
// op sew vl rs1 vd src expected_data expected_mask, all hex
// op 0 up 1 down 2 1up 3 1down, sew 0 8bit 1 16bit 2 32bit
0 0 10 00000003 01 0f0e0d0c0b0a09080706050403020100 0c0b0a09080706050403020100000000 fff8
0 1 08 00000002 02 0f0e0d0c0b0a09080706050403020100 0b0a0908070605040302010000000000 fff0
0 2 04 00000004 03 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 0000
0 2 03 00000001 04 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000a7a6a5a4a3a2a1a000000000 0ff0
1 0 10 00000005 05 0f0e0d0c0b0a09080706050403020100 00000000000f0e0d0c0b0a0908070605 ffff
1 1 08 00000003 06 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000000000afaeadacabaaa9a8a7a6 ffff
1 2 04 00000002 07 0f0e0d0c0b0a09080706050403020100 00000000000000000f0e0d0c0b0a0908 ffff
1 2 02 00000001 08 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000000000000000abaaa9a8a7a6a5a4 00ff
1 0 10 00000014 09 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 ffff
2 0 10 0000005a 0a 0f0e0d0c0b0a09080706050403020100 0e0d0c0b0a090807060504030201005a ffff
2 1 05 1234beef 0b afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000000000a7a6a5a4a3a2a1a0beef 03ff
2 2 04 cafe0123 0c 0f0e0d0c0b0a09080706050403020100 0b0a09080706050403020100cafe0123 ffff
3 0 10 000000a5 0d 0f0e0d0c0b0a09080706050403020100 a50f0e0d0c0b0a090807060504030201 ffff
3 1 06 0000c3d2 0e afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000c3d2abaaa9a8a7a6a5a4a3a2 0fff
3 0 01 00000077 0f 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000077 0001
1 0 00 00000001 10 0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 0000
2 0 00 00000033 11 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00000000000000000000000000000000 0000
0 0 0a 00000007 12 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 000000000000a2a1a000000000000000 0380
0 1 08 00000007 13 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 a1a00000000000000000000000000000 c000
3 1 08 00009876 1f 0f0e0d0c0b0a09080706050403020100 98760f0e0d0c0b0a0908070605040302 ffff

/* verilog.f */
common/vsld_pkg.sv
vsld/vsld_sequencer.sv
vsld/vsld_operand_buf.sv
vsld/vsld_result_asm.sv
hdl/vsld_top.sv
verification/vsld_chk.sv
verification/vsld_tb.sv

/* vsld/vsld_operand_buf.sv */
`timescale 1ns/1ps

/*
 * vector slide operand buffer, holds the source register and registers
 * the low and high operand chunks for each beat
 */
module vsld_operand_buf #(
    parameter  int unsigned VREG_W,
    parameter  int unsigned SLD_OP_W,
    localparam int unsigned CHUNKS = VREG_W / SLD_OP_W,
    localparam int unsigned SHFT_W = $clog2(SLD_OP_W / 8),
    localparam int unsigned IDX_W  = $clog2(CHUNKS) + 3,
    localparam int unsigned VL_W   = $clog2(VREG_W / 8) + 1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    load_i,
    input  logic [VREG_W-1:0]       src_i,
    input  logic                    beat_valid_i,
    input  logic                    beat_first_i,
    input  logic                    beat_last_i,
    input  logic signed [IDX_W-1:0] src_chunk_i,
    input  logic [SHFT_W-1:0]       op_shift_i,
    input  vsld_pkg::sld_op_e       op_i,
    input  vsld_pkg::vsew_e         sew_i,
    input  logic [VL_W-1:0]         vl_i,
    input  logic [31:0]             rs1_i,
    input  logic [4:0]              vd_i,

    output logic                    beat_valid_o,
    output logic                    beat_first_o,
    output logic                    beat_last_o,
    output logic signed [IDX_W-1:0] src_chunk_o,
    output logic [SHFT_W-1:0]       op_shift_o,
    output vsld_pkg::sld_op_e       op_o,
    output vsld_pkg::vsew_e         sew_o,
    output logic [VL_W-1:0]         vl_o,
    output logic [31:0]             rs1_o,
    output logic [4:0]              vd_o,
    output logic [SLD_OP_W-1:0]     operand_low_o,
    output logic [SLD_OP_W-1:0]     operand_high_o,
    output logic                    low_valid_o,
    output logic                    high_valid_o
);

    localparam int unsigned CIDX_W = $clog2(CHUNKS);

    logic [VREG_W-1:0]       src_q;
    logic signed [IDX_W-1:0] low_idx;
    logic                    low_in;
    logic                    high_in;

    // one copy per issuing operation; a new load lands on the edge
    // that also captures the last beat of the previous one
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            src_q <= src_i;
        end
    end

    // negative indices wrap to large unsigned values
    assign low_idx = src_chunk_i - IDX_W'(1);
    assign low_in  = $unsigned(low_idx) < CHUNKS;
    assign high_in = $unsigned(src_chunk_i) < CHUNKS;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= beat_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        beat_first_o   <= beat_first_i;
        beat_last_o    <= beat_last_i;
        src_chunk_o    <= src_chunk_i;
        op_shift_o     <= op_shift_i;
        op_o           <= op_i;
        sew_o          <= sew_i;
        vl_o           <= vl_i;
        rs1_o          <= rs1_i;
        vd_o           <= vd_i;
        // out of range chunks read as zero
        operand_low_o  <= low_in ? src_q[low_idx[CIDX_W-1:0]*SLD_OP_W +: SLD_OP_W] : '0;
        operand_high_o <= high_in ? src_q[src_chunk_i[CIDX_W-1:0]*SLD_OP_W +: SLD_OP_W] : '0;
        low_valid_o    <= low_in;
        high_valid_o   <= high_in;
    end

endmodule

/* vsld/vsld_result_asm.sv */
`timescale 1ns/1ps

/*
 * vector slide result assembly, byte shift of the operand pair, rs1 insert,
 * destination shift register, tail mask and the register write strobe
 */
module vsld_result_asm #(
    parameter  int unsigned VREG_W,
    parameter  int unsigned SLD_OP_W,
    localparam int unsigned CHUNKS = VREG_W / SLD_OP_W,
    localparam int unsigned SHFT_W = $clog2(SLD_OP_W / 8),
    localparam int unsigned IDX_W  = $clog2(CHUNKS) + 3,
    localparam int unsigned VL_W   = $clog2(VREG_W / 8) + 1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    beat_valid_i,
    input  logic                    beat_first_i,
    input  logic                    beat_last_i,
    input  logic signed [IDX_W-1:0] src_chunk_i,
    input  logic [SHFT_W-1:0]       op_shift_i,
    input  vsld_pkg::sld_op_e       op_i,
    input  vsld_pkg::vsew_e         sew_i,
    input  logic [VL_W-1:0]         vl_i,
    input  logic [31:0]             rs1_i,
    input  logic [4:0]              vd_i,
    input  logic [SLD_OP_W-1:0]     operand_low_i,
    input  logic [SLD_OP_W-1:0]     operand_high_i,
    input  logic                    low_valid_i,
    input  logic                    high_valid_i,

    output logic                    vreg_wr_en_o,
    output logic [VREG_W-1:0]       vreg_wr_o,
    output logic [4:0]              vreg_wr_addr_o,
    output logic [VREG_W/8-1:0]     vreg_wr_mask_o
);

    localparam int unsigned CB     = SLD_OP_W / 8;
    localparam int unsigned VMSK_W = VREG_W / 8;
    localparam int unsigned VLB_W  = VL_W + 2;

    logic [SLD_OP_W-1:0] result_d, result_q;
    logic [CB-1:0]       rmask_d, rmask_q;
    logic                res_valid_q;
    logic                res_first_q;
    logic                res_last_q;
    vsld_pkg::vsew_e     res_sew_q;
    logic [VL_W-1:0]     res_vl_q;
    logic [4:0]          res_vd_q;

    logic [VREG_W-1:0]   vd_shift_d, vd_shift_q;
    logic [VMSK_W-1:0]   vdmsk_shift_d, vdmsk_shift_q;
    logic [VLB_W-1:0]    vl_bytes;
    logic [VMSK_W-1:0]   tail_mask;

    logic                wr_en_q;
    logic [VREG_W-1:0]   wr_q;
    logic [VMSK_W-1:0]   wr_mask_q;
    logic [4:0]          wr_addr_q;

    ////////////////////////////////////////////////////////////////////////////
    // byte selection

    always_comb begin : slide_bytes
        int unsigned idx;
        int          dst_chunk;
        int          tgt;
        int          g;
        // 1-down results trail the source chunk by one plus the whole
        // chunks covered by one element
        dst_chunk = int'(src_chunk_i);
        if (op_i == vsld_pkg::SLD_1DOWN) begin
            dst_chunk = dst_chunk - 1 - (1 << sew_i) / int'(CB);
        end
        tgt       = (op_i == vsld_pkg::SLD_1UP) ? 0 : int'(vl_i) - 1;
        for (int i = 0; i < CB; i++) begin
            idx = int'(op_shift_i) + i;
            if (idx < CB) begin
                result_d[i*8 +: 8] = operand_low_i[idx*8 +: 8];
                rmask_d[i]         = low_valid_i;
            end else begin
                result_d[i*8 +: 8] = operand_high_i[(idx-CB)*8 +: 8];
                rmask_d[i]         = high_valid_i;
            end
            // rs1 replaces element 0 for 1-up, element vl-1 for 1-down
            g = dst_chunk * CB + i;
            if ((op_i == vsld_pkg::SLD_1UP || op_i == vsld_pkg::SLD_1DOWN) &&
                g >= 0 && (g >> sew_i) == tgt) begin
                result_d[i*8 +: 8] = rs1_i[(g & ((1 << sew_i) - 1))*8 +: 8];
            end
        end
        // only slide-up leaves elements unwritten
        if (op_i != vsld_pkg::SLD_UP) begin
            rmask_d = '1;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_valid_q <= 1'b0;
            wr_en_q     <= 1'b0;
        end else begin
            res_valid_q <= beat_valid_i;
            wr_en_q     <= res_valid_q & res_last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q    <= result_d;
        rmask_q     <= rmask_d;
        res_first_q <= beat_first_i;
        res_last_q  <= beat_last_i;
        res_sew_q   <= sew_i;
        res_vl_q    <= vl_i;
        res_vd_q    <= vd_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // destination assembly

    // first beat result falls off the bottom after all beats
    assign vd_shift_d    = {result_q, vd_shift_q[VREG_W-1:SLD_OP_W]};
    assign vdmsk_shift_d = {rmask_q,
                            res_first_q ? {(VMSK_W-CB){1'b0}} : vdmsk_shift_q[VMSK_W-1:CB]};

    // tail limit in bytes
    assign vl_bytes = VLB_W'(res_vl_q) << res_sew_q;

    always_comb begin
        for (int b = 0; b < VMSK_W; b++) begin
            tail_mask[b] = VLB_W'(b) < vl_bytes;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_valid_q) begin
            vd_shift_q    <= vd_shift_d;
            vdmsk_shift_q <= vdmsk_shift_d;
        end
        if (res_valid_q & res_last_q) begin
            wr_q      <= vd_shift_d;
            wr_mask_q <= vdmsk_shift_d & tail_mask;
            wr_addr_q <= res_vd_q;
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_o      = wr_q;
    assign vreg_wr_addr_o = wr_addr_q;
    assign vreg_wr_mask_o = wr_mask_q;

endmodule

/* vsld/vsld_sequencer.sv */
`timescale 1ns/1ps

/*
 * vector slide sequencer, accepts one operation per handshake, decodes the
 * slide amount and issues chunk count + 1 beats per operation
 */
module vsld_sequencer #(
    parameter  int unsigned VREG_W,
    parameter  int unsigned SLD_OP_W,
    localparam int unsigned CHUNKS = VREG_W / SLD_OP_W,
    localparam int unsigned SHFT_W = $clog2(SLD_OP_W / 8),
    localparam int unsigned IDX_W  = $clog2(CHUNKS) + 3,
    localparam int unsigned VL_W   = $clog2(VREG_W / 8) + 1
) (
    input  logic                    clk_i,
    input  logic                    async_rst_ni,

    input  logic                    op_rdy_i,
    output logic                    op_ack_o,
    input  vsld_pkg::sld_op_e       op_i,
    input  vsld_pkg::vsew_e         sew_i,
    input  logic [VL_W-1:0]         vl_i,
    input  logic [31:0]             rs1_i,
    input  logic [4:0]              vd_i,
    input  logic [VREG_W-1:0]       src_i,

    output logic                    load_o,
    output logic [VREG_W-1:0]       src_o,
    output logic                    beat_valid_o,
    output logic                    beat_first_o,
    output logic                    beat_last_o,
    output logic signed [IDX_W-1:0] src_chunk_o,
    output logic [SHFT_W-1:0]       op_shift_o,
    output vsld_pkg::sld_op_e       op_o,
    output vsld_pkg::vsew_e         sew_o,
    output logic [VL_W-1:0]         vl_o,
    output logic [31:0]             rs1_o,
    output logic [4:0]              vd_o
);

    localparam int unsigned CNT_W = $clog2(CHUNKS + 1);
    localparam int unsigned OFF_W = $clog2(VREG_W / 8);

    // slide offset in bytes, or split into chunk index and byte shift
    typedef union packed {
        logic [OFF_W-1:0] bytes;
        struct packed {
            logic [OFF_W-SHFT_W-1:0] chunk;
            logic [SHFT_W-1:0]       shift;
        } part;
    } sld_off_u;

    sld_off_u                off;
    logic                    ovf;
    logic                    is_up;
    logic signed [IDX_W-1:0] chunk_s;
    logic signed [IDX_W-1:0] base_d, base_q;
    logic [SHFT_W-1:0]       shift_d, shift_q;
    logic                    busy_q;
    logic [CNT_W-1:0]        count_q;
    logic                    last;

    vsld_pkg::sld_op_e       op_q;
    vsld_pkg::vsew_e         sew_q;
    logic [VL_W-1:0]         vl_q;
    logic [31:0]             rs1_q;
    logic [4:0]              vd_q;

    ////////////////////////////////////////////////////////////////////////////
    // offset decode

    always_comb begin
        off.bytes = '0;
        ovf       = 1'b0;
        if (op_i == vsld_pkg::SLD_1UP || op_i == vsld_pkg::SLD_1DOWN) begin
            // one element, never beyond the register
            off.bytes = OFF_W'(1) << sew_i;
        end else begin
            case (sew_i)
                vsld_pkg::VSEW_8: begin
                    off.bytes = rs1_i[OFF_W-1:0];
                    ovf       = |rs1_i[31:OFF_W];
                end
                vsld_pkg::VSEW_16: begin
                    off.bytes = {rs1_i[OFF_W-2:0], 1'b0};
                    ovf       = |rs1_i[31:OFF_W-1];
                end
                default: begin
                    off.bytes = {rs1_i[OFF_W-3:0], 2'b00};
                    ovf       = |rs1_i[31:OFF_W-2];
                end
            endcase
        end
    end

    assign is_up   = (op_i == vsld_pkg::SLD_UP) || (op_i == vsld_pkg::SLD_1UP);
    assign chunk_s = IDX_W'(off.part.chunk);

    // chunk index of the first beat, counted up by one per beat
    always_comb begin
        if (ovf) begin
            // park every chunk of the operation out of range
            base_d  = is_up ? -IDX_W'(CHUNKS + 1) : IDX_W'(CHUNKS + 1);
            shift_d = '0;
        end else if (is_up) begin
            // up lags by the offset, rounded up to whole chunks
            base_d  = -chunk_s - IDX_W'(off.part.shift != '0);
            shift_d = -off.part.shift;
        end else begin
            base_d  = chunk_s;
            shift_d = off.part.shift;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat counter

    assign last     = busy_q && (count_q == CNT_W'(CHUNKS));
    assign op_ack_o = op_rdy_i & (~busy_q | last);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (op_ack_o) begin
            busy_q  <= 1'b1;
            count_q <= '0;
        end else if (busy_q) begin
            busy_q  <= ~last;
            count_q <= count_q + 1'b1;
        end
    end

    // operation context, held for all beats
    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            base_q  <= base_d;
            shift_q <= shift_d;
            op_q    <= op_i;
            sew_q   <= sew_i;
            vl_q    <= vl_i;
            rs1_q   <= rs1_i;
            vd_q    <= vd_i;
        end
    end

    assign load_o       = op_ack_o;
    assign src_o        = src_i;
    assign beat_valid_o = busy_q;
    assign beat_first_o = busy_q && (count_q == '0);
    assign beat_last_o  = last;
    assign src_chunk_o  = base_q + IDX_W'(count_q);
    assign op_shift_o   = shift_q;
    assign op_o         = op_q;
    assign sew_o        = sew_q;
    assign vl_o         = vl_q;
    assign rs1_o        = rs1_q;
    assign vd_o         = vd_q;

endmodule
